// File: design/uart_pkg.sv
// UART shared definitions
// rate table, frame configuration, event bundle and parity helper
package uart_pkg;

	// master clock and oversampling
	localparam int CLK_HZ       = 100_000_000;
	localparam int OVERSAMPLE   = 8;
	localparam int SAMPLE_POINT = 4;
	localparam int TICK_W       = $clog2(OVERSAMPLE);

	// status pulse length in clocks
	localparam int PULSE_CYCLES = 100;
	localparam int PULSE_W      = $clog2(PULSE_CYCLES + 1);

	// spike filter saturation range
	localparam int FILTER_DEPTH = 3;
	localparam int FILTER_W     = $clog2(FILTER_DEPTH + 1);

	typedef logic [3:0] baud_sel_t;
	typedef logic [7:0] data_t;

	typedef struct packed {
		logic       stop_two;
		logic       parity_en;
		logic       parity_even;
		// 0 -> 8 bits ... 3 -> 5 bits
		logic [1:0] data_len;
	} uart_cfg_t;

	typedef struct packed {
		logic rx_done;
		logic parity_err;
		logic overrun;
		logic tx_done;
	} uart_evt_t;

	// clocks per oversample tick, rounded to nearest
	function automatic logic [15:0] div_of(int rate);
		return 16'((CLK_HZ + (rate * OVERSAMPLE) / 2) / (rate * OVERSAMPLE));
	endfunction

	// indexed by baud_sel_t, slowest first
	localparam logic [15:0] BAUD_DIV [16] = '{
		div_of(2400),   div_of(4800),   div_of(9600),   div_of(14400),
		div_of(19200),  div_of(28800),  div_of(38400),  div_of(56000),
		div_of(57600),  div_of(115200), div_of(128000), div_of(153600),
		div_of(230400), div_of(256000), div_of(460800), div_of(921600)
	};

	function automatic logic [3:0] data_bits(uart_cfg_t cfg);
		return 4'd8 - {2'b00, cfg.data_len};
	endfunction

	// xor of the active data bits, inverted for odd parity
	function automatic logic parity_of(data_t data, uart_cfg_t cfg);
		logic ones;
		ones = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (i < data_bits(cfg))
				ones ^= data[i];
		end
		if (!cfg.parity_en)
			return 1'b0;
		return cfg.parity_even ? ones : ~ones;
	endfunction

endpackage

// File: design/baud_gen.sv
// baud tick generator
// one-clock os_tick every BAUD_DIV[baud_sel] clocks
`timescale 1ns/1ps

module baud_gen import uart_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  baud_sel_t baud_sel,
	output logic      os_tick
);

	logic [15:0] div_cnt;

	// down-counter, tick on reload
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			os_tick <= 1'b0;
		end else if (div_cnt == '0) begin
			div_cnt <= BAUD_DIV[baud_sel] - 16'd1;
			os_tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt - 16'd1;
			os_tick <= 1'b0;
		end
	end

	// a zero entry would stall the receiver and transmitter
	a_div_nonzero: assert property (
		@(posedge clk) disable iff (reset)
		BAUD_DIV[baud_sel] != 16'd0
	) else $error("baud divisor is zero for code %0d", baud_sel);

endmodule

// File: design/rx_line_filter.sv
// receive line conditioner
// two-flop synchronizer followed by a saturating spike filter
`timescale 1ns/1ps

module rx_line_filter import uart_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic serial_in,
	output logic line
);

	logic [1:0]          sync;
	logic [FILTER_W-1:0] flt_cnt;
	logic [FILTER_W-1:0] flt_cnt_next;

	// count toward the synchronized level, saturate at the ends
	always_comb begin
		flt_cnt_next = flt_cnt;
		if (sync[1] && flt_cnt != FILTER_W'(FILTER_DEPTH))
			flt_cnt_next = flt_cnt + 1'b1;
		else if (!sync[1] && flt_cnt != '0)
			flt_cnt_next = flt_cnt - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			// idle line is high
			sync    <= 2'b11;
			flt_cnt <= FILTER_W'(FILTER_DEPTH);
			line    <= 1'b1;
		end else begin
			sync    <= {sync[0], serial_in};
			flt_cnt <= flt_cnt_next;
			// output only moves at the range ends
			if (flt_cnt_next == FILTER_W'(FILTER_DEPTH))
				line <= 1'b1;
			else if (flt_cnt_next == '0)
				line <= 1'b0;
		end
	end

endmodule

// File: design/uart_rx.sv
// UART receiver
// oversampled FSM with mid-bit sampling, parity check and overrun detect
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      os_tick,
	input  logic      line,
	input  uart_cfg_t cfg,
	input  logic      done_pending,
	output data_t     rx_data,
	output logic      rx_done,
	output logic      parity_err,
	output logic      overrun
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_PARITY,
		S_STOP
	} rx_state_t;

	rx_state_t         state;
	logic [TICK_W-1:0] tick_cnt;
	logic [2:0]        bit_cnt;
	data_t             shift_reg;
	logic              par_bit;
	logic              sample;
	logic              last_data;
	data_t             rx_word;

	// sample point inside the current bit
	assign sample    = os_tick && tick_cnt == TICK_W'(SAMPLE_POINT);
	assign last_data = {1'b0, bit_cnt} == data_bits(cfg) - 4'd1;
	// bits arrive LSB first, short words end up high in the shifter
	assign rx_word   = shift_reg >> (4'd8 - data_bits(cfg));

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= S_IDLE;
			tick_cnt   <= '0;
			bit_cnt    <= '0;
			rx_data    <= '0;
			rx_done    <= 1'b0;
			parity_err <= 1'b0;
			overrun    <= 1'b0;
		end else begin
			// strobes are one clock wide
			rx_done    <= 1'b0;
			parity_err <= 1'b0;
			overrun    <= 1'b0;
			if (os_tick && state != S_IDLE)
				tick_cnt <= (tick_cnt == TICK_W'(OVERSAMPLE - 1)) ? '0 : tick_cnt + 1'b1;
			case (state)
				S_IDLE: begin
					// falling edge seen on this tick counts as tick 0
					if (os_tick && !line) begin
						state    <= S_START;
						tick_cnt <= TICK_W'(1);
					end
				end
				S_START: begin
					if (sample) begin
						if (!line) begin
							state   <= S_DATA;
							bit_cnt <= '0;
							// previous byte still unacknowledged
							overrun <= done_pending;
						end else begin
							// glitch, not a start bit
							state <= S_IDLE;
						end
					end
				end
				S_DATA: begin
					if (sample) begin
						shift_reg <= {line, shift_reg[7:1]};
						bit_cnt   <= bit_cnt + 3'd1;
						if (last_data) begin
							bit_cnt <= '0;
							state   <= cfg.parity_en ? S_PARITY : S_STOP;
						end
					end
				end
				S_PARITY: begin
					if (sample) begin
						par_bit <= line;
						state   <= S_STOP;
					end
				end
				S_STOP: begin
					if (sample) begin
						if (cfg.stop_two && bit_cnt == '0) begin
							bit_cnt <= 3'd1;
						end else begin
							state      <= S_IDLE;
							rx_data    <= rx_word;
							rx_done    <= 1'b1;
							parity_err <= cfg.parity_en && par_bit != parity_of(rx_word, cfg);
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// completion strobes only follow the final stop sample
	a_done_at_stop: assert property (
		@(posedge clk) disable iff (reset)
		(rx_done || parity_err) |-> (state == S_IDLE && $past(state) == S_STOP)
	) else $error("rx strobe outside stop-to-idle transition");

endmodule

// File: design/uart_tx.sv
// UART transmitter
// frames a captured byte as start, data, optional parity and stop bits
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      os_tick,
	input  uart_cfg_t cfg,
	input  logic      tx_start,
	input  data_t     tx_data,
	output logic      tx_pin,
	output logic      tx_busy,
	output logic      tx_done
);

	typedef enum logic [2:0] {
		T_IDLE,
		T_WAIT,
		T_START,
		T_DATA,
		T_PARITY,
		T_STOP
	} tx_state_t;

	tx_state_t         state;
	logic [TICK_W-1:0] tick_cnt;
	logic [2:0]        bit_cnt;
	data_t             shift_reg;
	logic              par_bit;
	logic              bit_end;
	logic              last_data;

	// every bit spans OVERSAMPLE ticks
	assign bit_end   = os_tick && tick_cnt == TICK_W'(OVERSAMPLE - 1);
	assign last_data = {1'b0, bit_cnt} == data_bits(cfg) - 4'd1;
	assign tx_busy   = state != T_IDLE;

	always_comb begin
		case (state)
			T_START:  tx_pin = 1'b0;
			T_DATA:   tx_pin = shift_reg[0];
			T_PARITY: tx_pin = par_bit;
			// idle, wait and stop all hold the line high
			default:  tx_pin = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= T_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			tx_done  <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (os_tick && state != T_IDLE && state != T_WAIT)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				T_IDLE: begin
					if (tx_start) begin
						shift_reg <= tx_data;
						par_bit   <= parity_of(tx_data, cfg);
						state     <= T_WAIT;
					end
				end
				T_WAIT: begin
					// align the start bit to the tick grid
					if (os_tick) begin
						state    <= T_START;
						tick_cnt <= '0;
					end
				end
				T_START: begin
					if (bit_end) begin
						state   <= T_DATA;
						bit_cnt <= '0;
					end
				end
				T_DATA: begin
					if (bit_end) begin
						shift_reg <= shift_reg >> 1;
						bit_cnt   <= bit_cnt + 3'd1;
						if (last_data) begin
							bit_cnt <= '0;
							state   <= cfg.parity_en ? T_PARITY : T_STOP;
						end
					end
				end
				T_PARITY: begin
					if (bit_end)
						state <= T_STOP;
				end
				T_STOP: begin
					if (bit_end) begin
						if (cfg.stop_two && bit_cnt == '0) begin
							bit_cnt <= 3'd1;
						end else begin
							// busy drops with the done strobe
							state   <= T_IDLE;
							tx_done <= 1'b1;
						end
					end
				end
				default: state <= T_IDLE;
			endcase
		end
	end

	a_idle_high: assert property (
		@(posedge clk) disable iff (reset)
		!tx_busy |-> tx_pin
	) else $error("tx_pin low while transmitter idle");

	a_done_single: assert property (
		@(posedge clk) disable iff (reset)
		tx_done |=> !tx_done
	) else $error("tx_done wider than one clock");

endmodule

// File: design/event_status.sv
// per-event status
// sticky flag with clear, and a fixed-length pulse gated by an enable
`timescale 1ns/1ps

module event_status import uart_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic evt,
	input  logic clear,
	input  logic pulse_en,
	output logic flag,
	output logic pulse
);

	logic [PULSE_W-1:0] pulse_cnt;

	assign pulse = pulse_cnt != '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			flag      <= 1'b0;
			pulse_cnt <= '0;
		end else begin
			// clear has priority over a new event
			if (clear)
				flag <= 1'b0;
			else if (evt)
				flag <= 1'b1;
			// a fresh event restarts the pulse
			if (evt && pulse_en)
				pulse_cnt <= PULSE_W'(PULSE_CYCLES);
			else if (pulse_cnt != '0)
				pulse_cnt <= pulse_cnt - 1'b1;
		end
	end

	// without a retrigger the pulse is gone after PULSE_CYCLES clocks
	a_pulse_len: assert property (
		@(posedge clk) disable iff (reset)
		!(evt && pulse_en) [*PULSE_CYCLES] |=> !pulse
	) else $error("status pulse longer than PULSE_CYCLES");

endmodule

// File: design/uart_core.sv
// UART top level
// baud generator, rx filter, receiver, transmitter and four status blocks
`timescale 1ns/1ps

module uart_core import uart_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  uart_cfg_t cfg,
	input  baud_sel_t baud_sel,
	input  logic      rx_pin,
	output logic      tx_pin,
	input  logic      tx_start,
	input  data_t     tx_data,
	output logic      tx_busy,
	output data_t     rx_data,
	input  uart_evt_t pulse_en,
	input  uart_evt_t flag_clear,
	output uart_evt_t flags,
	output uart_evt_t pulses
);

	logic      os_tick;
	logic      rx_line;
	logic      rx_done_s;
	logic      parity_err_s;
	logic      overrun_s;
	logic      tx_done_s;
	uart_evt_t evt_strobe;

	// shared oversample tick
	baud_gen u_baud_gen (
		.clk      (clk),
		.reset    (reset),
		.baud_sel (baud_sel),
		.os_tick  (os_tick)
	);

	rx_line_filter u_rx_line_filter (
		.clk       (clk),
		.reset     (reset),
		.serial_in (rx_pin),
		.line      (rx_line)
	);

	// overrun watches the rx_done flag
	uart_rx u_uart_rx (
		.clk          (clk),
		.reset        (reset),
		.os_tick      (os_tick),
		.line         (rx_line),
		.cfg          (cfg),
		.done_pending (flags.rx_done),
		.rx_data      (rx_data),
		.rx_done      (rx_done_s),
		.parity_err   (parity_err_s),
		.overrun      (overrun_s)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.reset    (reset),
		.os_tick  (os_tick),
		.cfg      (cfg),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_pin   (tx_pin),
		.tx_busy  (tx_busy),
		.tx_done  (tx_done_s)
	);

	assign evt_strobe = '{
		rx_done:    rx_done_s,
		parity_err: parity_err_s,
		overrun:    overrun_s,
		tx_done:    tx_done_s
	};

	// one status block per event bit
	for (genvar i = 0; i < 4; i++) begin : g_status
		event_status u_event_status (
			.clk      (clk),
			.reset    (reset),
			.evt      (evt_strobe[i]),
			.clear    (flag_clear[i]),
			.pulse_en (pulse_en[i]),
			.flag     (flags[i]),
			.pulse    (pulses[i])
		);
	end

endmodule

// File: tests/uart_tb.sv
// UART core testbench
// directed tests with a serial line model, tx decoder and loopback mux
`timescale 1ns/1ps

module uart_tb import uart_pkg::*; ();

	// fastest rate keeps frames short
	localparam baud_sel_t TEST_RATE = 4'd15;
	localparam int BIT_CLKS = int'(BAUD_DIV[TEST_RATE]) * OVERSAMPLE;
	// 4 + 16 + 1 + 2 frames, never more than 12 bits each
	localparam int FRAME_BITS = 23 * 12;
	localparam int TIMEOUT_CYCLES = (3 * (FRAME_BITS * BIT_CLKS + 2 * PULSE_CYCLES)) / 2;

	logic      clk;
	logic      reset;
	uart_cfg_t cfg;
	baud_sel_t baud_sel;
	logic      rx_pin;
	logic      tx_pin;
	logic      tx_start;
	data_t     tx_data;
	logic      tx_busy;
	data_t     rx_data;
	uart_evt_t pulse_en;
	uart_evt_t flag_clear;
	uart_evt_t flags;
	uart_evt_t pulses;

	// line model side
	logic model_pin;
	logic loopback;
	int   seed   = 10;
	int   checks = 0;
	int   errors = 0;
	int   cycles = 0;

	assign rx_pin = loopback ? tx_pin : model_pin;

	uart_core u_uart_core (
		.clk        (clk),
		.reset      (reset),
		.cfg        (cfg),
		.baud_sel   (baud_sel),
		.rx_pin     (rx_pin),
		.tx_pin     (tx_pin),
		.tx_start   (tx_start),
		.tx_data    (tx_data),
		.tx_busy    (tx_busy),
		.rx_data    (rx_data),
		.pulse_en   (pulse_en),
		.flag_clear (flag_clear),
		.flags      (flags),
		.pulses     (pulses)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic int bit_clks();
		return int'(BAUD_DIV[baud_sel]) * OVERSAMPLE;
	endfunction

	// parity from the frame rule, low nbits only
	function automatic logic expected_parity(input data_t d, input int nbits, input logic even);
		int ones;
		ones = 0;
		for (int i = 0; i < nbits; i++)
			ones += d[i];
		return even ? logic'(ones % 2) : logic'(1 - ones % 2);
	endfunction

	task automatic check_data(input data_t got, input data_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_evt(input uart_evt_t got, input uart_evt_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// bit-bang one frame onto the model pin, optionally with bad parity
	task automatic send_frame(input data_t d, input int nbits, input uart_cfg_t c,
			input logic flip_par);
		logic frame [$];
		frame.push_back(1'b0);
		for (int i = 0; i < nbits; i++)
			frame.push_back(d[i]);
		if (c.parity_en)
			frame.push_back(expected_parity(d, nbits, c.parity_even) ^ flip_par);
		frame.push_back(1'b1);
		if (c.stop_two)
			frame.push_back(1'b1);
		foreach (frame[k]) begin
			model_pin = frame[k];
			repeat (bit_clks()) @(negedge clk);
		end
	endtask

	// start the transmitter and decode tx_pin at bit centres
	task automatic transmit_and_decode(input data_t d, input int nbits, input uart_cfg_t c,
			output data_t got, output logic par);
		got      = '0;
		par      = 1'b0;
		tx_data  = d;
		tx_start = 1'b1;
		@(negedge clk);
		tx_start = 1'b0;
		check_bit(tx_busy, 1'b1, "tx_busy after start");
		while (tx_pin !== 1'b0)
			@(negedge clk);
		// centre of start bit
		repeat (bit_clks() / 2) @(negedge clk);
		check_bit(tx_pin, 1'b0, "tx start bit");
		for (int i = 0; i < nbits; i++) begin
			repeat (bit_clks()) @(negedge clk);
			got[i] = tx_pin;
		end
		if (c.parity_en) begin
			repeat (bit_clks()) @(negedge clk);
			par = tx_pin;
		end
		repeat (bit_clks()) @(negedge clk);
		check_bit(tx_pin, 1'b1, "tx stop bit");
		if (c.stop_two) begin
			repeat (bit_clks()) @(negedge clk);
			check_bit(tx_pin, 1'b1, "tx second stop bit");
		end
		// busy drops at the end of the last stop bit, flag one clock later
		while (tx_busy)
			@(negedge clk);
		@(negedge clk);
	endtask

	task automatic wait_rx_done();
		while (!flags.rx_done)
			@(negedge clk);
	endtask

	task automatic clear_flags(input uart_evt_t which);
		flag_clear = which;
		@(negedge clk);
		flag_clear = '0;
	endtask

	// count clocks while a selected pulse is high
	task automatic measure_pulse(input uart_evt_t which, output int len);
		while ((pulses & which) == '0)
			@(negedge clk);
		len = 0;
		while ((pulses & which) != '0) begin
			len++;
			@(negedge clk);
		end
	endtask

	// note any selected pulse seen during the next ncycles clocks
	task automatic watch_pulses(input uart_evt_t which, input int ncycles, output logic seen);
		seen = 1'b0;
		for (int i = 0; i < ncycles; i++) begin
			if ((pulses & which) != '0)
				seen = 1'b1;
			@(negedge clk);
		end
	endtask

	task automatic test_reset_state();
		check_bit(tx_pin, 1'b1, "tx_pin after reset");
		check_bit(tx_busy, 1'b0, "tx_busy after reset");
		check_evt(flags, '0, "flags after reset");
		check_evt(pulses, '0, "pulses after reset");
		check_data(rx_data, '0, "rx_data after reset");
	endtask

	task automatic test_loopback_8n1();
		uart_cfg_t c;
		data_t     d;
		data_t     got;
		logic      par;
		c        = '0;
		cfg      = c;
		loopback = 1'b1;
		for (int n = 0; n < 4; n++) begin
			d = data_t'($random(seed));
			transmit_and_decode(d, 8, c, got, par);
			check_data(got, d, "8N1 tx_pin frame");
			wait_rx_done();
			check_data(rx_data, d, "8N1 loopback rx_data");
			check_evt(flags, uart_evt_t'{rx_done: 1'b1, parity_err: 1'b0, overrun: 1'b0,
				tx_done: 1'b1}, "8N1 flags");
			// each flag on its own clear
			clear_flags(uart_evt_t'{rx_done: 1'b1, parity_err: 1'b0, overrun: 1'b0,
				tx_done: 1'b0});
			check_evt(flags, uart_evt_t'{rx_done: 1'b0, parity_err: 1'b0, overrun: 1'b0,
				tx_done: 1'b1}, "8N1 flags after rx_done clear");
			clear_flags(uart_evt_t'{rx_done: 1'b0, parity_err: 1'b0, overrun: 1'b0,
				tx_done: 1'b1});
			check_evt(flags, '0, "8N1 flags after tx_done clear");
		end
	endtask

	task automatic test_config_sweep();
		uart_cfg_t c;
		data_t     d;
		data_t     got;
		data_t     mask;
		logic      par;
		loopback = 1'b1;
		for (int nbits = 5; nbits <= 8; nbits++) begin
			for (int even = 0; even < 2; even++) begin
				for (int two = 0; two < 2; two++) begin
					c.stop_two    = two[0];
					c.parity_en   = 1'b1;
					c.parity_even = even[0];
					c.data_len    = 2'(8 - nbits);
					cfg  = c;
					d    = data_t'($random(seed));
					mask = data_t'((1 << nbits) - 1);
					transmit_and_decode(d, nbits, c, got, par);
					check_data(got, d & mask, $sformatf("sweep %0d bits tx data", nbits));
					check_bit(par, expected_parity(d, nbits, c.parity_even),
						$sformatf("sweep %0d bits even %0d tx parity", nbits, even));
					wait_rx_done();
					check_data(rx_data & mask, d & mask, $sformatf("sweep %0d bits rx_data", nbits));
					check_bit(flags.parity_err, 1'b0, "sweep parity_err flag");
					clear_flags('1);
				end
			end
		end
	endtask

	task automatic test_parity_error();
		uart_cfg_t c;
		data_t     d;
		int        len;
		c             = '0;
		c.parity_en   = 1'b1;
		c.parity_even = 1'b1;
		cfg           = c;
		loopback      = 1'b0;
		pulse_en      = uart_evt_t'{rx_done: 1'b0, parity_err: 1'b1, overrun: 1'b0, tx_done: 1'b0};
		d             = data_t'($random(seed));
		fork
			send_frame(d, 8, c, 1'b1);
			measure_pulse(pulse_en, len);
		join
		check_bit(len == PULSE_CYCLES, 1'b1, $sformatf("parity_err pulse length %0d", len));
		check_bit(flags.parity_err, 1'b1, "parity_err flag on bad parity");
		check_bit(flags.rx_done, 1'b1, "rx_done flag on bad parity frame");
		clear_flags('1);
		pulse_en = '0;
	endtask

	task automatic test_overrun();
		uart_cfg_t c;
		data_t     d;
		logic      saw_pulse;
		c         = '0;
		cfg       = c;
		loopback  = 1'b0;
		pulse_en  = '0;
		d = data_t'($random(seed));
		send_frame(d, 8, c, 1'b0);
		wait_rx_done();
		check_evt(flags, uart_evt_t'{rx_done: 1'b1, parity_err: 1'b0, overrun: 1'b0,
			tx_done: 1'b0}, "flags after first frame");
		check_evt(pulses, '0, "pulses after first frame");
		// second frame with rx_done still pending, pulses watched from its start
		d = data_t'($random(seed));
		fork
			send_frame(d, 8, c, 1'b0);
			watch_pulses(uart_evt_t'{rx_done: 1'b1, parity_err: 1'b0, overrun: 1'b1,
				tx_done: 1'b0}, 10 * bit_clks() + PULSE_CYCLES, saw_pulse);
		join
		check_data(rx_data, d, "second frame rx_data");
		check_bit(flags.overrun, 1'b1, "overrun flag");
		check_bit(flags.rx_done, 1'b1, "rx_done flag after second frame");
		check_bit(saw_pulse, 1'b0, "rx_done or overrun pulse while disabled");
		clear_flags('1);
	endtask

	initial begin
		reset      = 1'b1;
		cfg        = '0;
		baud_sel   = TEST_RATE;
		model_pin  = 1'b1;
		loopback   = 1'b0;
		tx_start   = 1'b0;
		tx_data    = '0;
		pulse_en   = '0;
		flag_clear = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		test_reset_state();
		test_loopback_8n1();
		test_config_sweep();
		test_parity_error();
		test_overrun();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: flist.f
design/uart_pkg.sv
design/baud_gen.sv
design/rx_line_filter.sv
design/uart_rx.sv
design/uart_tx.sv
design/event_status.sv
design/uart_core.sv
tests/uart_tb.sv

// File: Bender.yml
package:
  name: uart_core

sources:
  - design/uart_pkg.sv
  - design/baud_gen.sv
  - design/rx_line_filter.sv
  - design/uart_rx.sv
  - design/uart_tx.sv
  - design/event_status.sv
  - design/uart_core.sv
  - target: simulation
    files:
      - tests/uart_tb.sv
